/* flist.f */
verilog/exec_pkg.sv
verilog/exec_op_classify.sv
verilog/exec_alu.sv
verilog/exec_branch_unit.sv
verilog/exec_result_reg.sv
verilog/execute.sv
testbench/tb_execute.sv

/* testbench/tb_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_execute import exec_pkg::*; ();

    // run length
    localparam int N_ITEMS    = 1000;
    // timeout leaves room for stalls and the drain
    localparam int MAX_CYCLES = 2 * N_ITEMS;
    // expected item packs result, target, taken, jump, write
    localparam int EXP_W      = 2 * XLEN + 3;

    logic              clk;
    logic              rst;
    logic              valid_i;
    logic              ready_o;
    logic [INST_W-1:0] inst_i;
    logic [XLEN-1:0]   operand1_i;
    logic [XLEN-1:0]   operand2_i;
    logic [XLEN-1:0]   imm_i;
    logic [XLEN-1:0]   pc_i;
    logic              valid_o;
    logic              ready_i;
    logic [XLEN-1:0]   alu_result_o;
    logic [XLEN-1:0]   target_o;
    logic              branch_taken_o;
    logic              jump_o;
    logic              write_reg_o;

    // scoreboard
    logic [EXP_W-1:0]  exp_q[$];
    logic [XLEN-1:0]   exp_result;
    logic [XLEN-1:0]   exp_target;
    logic              exp_taken;
    logic              exp_jump;
    logic              exp_write;
    int                exp_count = 0;
    logic              seen_accept = 1'b0;
    int                checked = 0;
    int                errors = 0;
    int                cycles = 0;

    execute dut (
        .i_clk          (clk),
        .rst_i          (rst),
        .valid_i        (valid_i),
        .ready_o        (ready_o),
        .inst_i         (inst_i),
        .operand1_i     (operand1_i),
        .operand2_i     (operand2_i),
        .imm_i          (imm_i),
        .pc_i           (pc_i),
        .valid_o        (valid_o),
        .ready_i        (ready_i),
        .alu_result_o   (alu_result_o),
        .target_o       (target_o),
        .branch_taken_o (branch_taken_o),
        .jump_o         (jump_o),
        .write_reg_o    (write_reg_o)
    );

    // 4 ns period
    always #2 clk = ~clk;

    task automatic flag_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    // sign bits differ means the negative one is smaller
    function automatic logic less_signed(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        return (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : (a < b);
    endfunction

    function automatic logic [XLEN-1:0] shift_right_arith(input logic [XLEN-1:0] a,
                                                          input logic [4:0] sh);
        logic [2*XLEN-1:0] ext;
        ext = {{XLEN{a[XLEN-1]}}, a} >> sh;
        return ext[XLEN-1:0];
    endfunction

    // reference model of one item
    function automatic logic [EXP_W-1:0] model_item(input logic [INST_W-1:0] word,
            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
            input logic [XLEN-1:0] imm, input logic [XLEN-1:0] pc);
        logic [XLEN-1:0] res;
        logic [XLEN-1:0] tgt;
        logic            tk;
        logic            jp;
        logic            wr;
        int              pos;
        res = '0;
        tgt = '0;
        tk  = 1'b0;
        jp  = 1'b0;
        wr  = 1'b1;
        pos = -1;
        for (int k = 0; k < INST_W; k++) begin
            if (word[k]) pos = k;
        end
        case (pos)
            INST_ADD:   res = a + b;
            INST_SUB:   res = a - b;
            INST_XOR:   res = a ^ b;
            INST_OR:    res = a | b;
            INST_AND:   res = a & b;
            INST_SLL:   res = a << b[4:0];
            INST_SRL:   res = a >> b[4:0];
            INST_SRA:   res = shift_right_arith(a, b[4:0]);
            INST_SLT:   res = {31'b0, less_signed(a, b)};
            INST_SLTU:  res = {31'b0, a < b};
            INST_ADDI:  res = a + imm;
            INST_XORI:  res = a ^ imm;
            INST_ORI:   res = a | imm;
            INST_ANDI:  res = a & imm;
            INST_SLLI:  res = a << imm[4:0];
            INST_SRLI:  res = a >> imm[4:0];
            INST_SRAI:  res = shift_right_arith(a, imm[4:0]);
            INST_SLTI:  res = {31'b0, less_signed(a, imm)};
            INST_SLTIU: res = {31'b0, a < imm};
            // load address
            INST_LB, INST_LH, INST_LW, INST_LBU, INST_LHU: res = a + imm;
            // store address without write back
            INST_SB, INST_SH, INST_SW: begin
                res = a + imm;
                wr  = 1'b0;
            end
            INST_BEQ:   tk = (a == b);
            INST_BNE:   tk = (a != b);
            INST_BLT:   tk = less_signed(a, b);
            INST_BGE:   tk = !less_signed(a, b);
            INST_BLTU:  tk = (a < b);
            INST_BGEU:  tk = !(a < b);
            INST_JAL: begin
                res = pc + 32'd4;
                tgt = pc + imm;
                jp  = 1'b1;
            end
            INST_JALR: begin
                res = pc + 32'd4;
                tgt = a + imm;
                jp  = 1'b1;
            end
            INST_AUIPC: res = pc + imm;
            // unknown, dropped or empty word
            default:    wr = 1'b0;
        endcase
        // all six branches are contiguous in the word
        if (pos >= INST_BEQ && pos <= INST_BGEU) begin
            tgt = pc + imm;
            wr  = 1'b0;
        end
        return {res, tgt, tk, jp, wr};
    endfunction

    // mostly kept ops, some dropped bits, bit 0 and the empty word
    function automatic logic [INST_W-1:0] pick_inst_word();
        int r;
        r = $urandom % 44;
        if (r < 36) return 64'd1 << (r + 1);
        else if (r < 40) return 64'd1 << (37 + $urandom % 27);
        else if (r < 42) return 64'd1;
        else return 64'd0;
    endfunction

    // corner values now and then
    function automatic logic [XLEN-1:0] pick_operand();
        case ($urandom % 8)
            0: return 32'h0000_0000;
            1: return 32'h8000_0000;
            2: return 32'hffff_ffff;
            3: return $urandom % 64;
            default: return $urandom;
        endcase
    endfunction

    task automatic load_random_item();
        valid_i    = 1'b1;
        inst_i     = pick_inst_word();
        operand1_i = pick_operand();
        // equal operands so beq/bge see ties
        operand2_i = ($urandom % 4 == 0) ? operand1_i : pick_operand();
        imm_i      = pick_operand();
        // word aligned pc
        pc_i       = $urandom & 32'hffff_fffc;
    endtask

    // track accepted items and the one currently on the outputs
    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
        end else begin
            if (valid_o && ready_i) begin
                if (exp_q.size() > 0) void'(exp_q.pop_front());
                checked++;
            end
            if (valid_i && ready_o) begin
                exp_q.push_back(model_item(inst_i, operand1_i, operand2_i, imm_i, pc_i));
                seen_accept = 1'b1;
            end
        end
        exp_count = exp_q.size();
        if (exp_q.size() > 0) begin
            {exp_result, exp_target, exp_taken, exp_jump, exp_write} = exp_q[0];
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    // outputs stay cleared until something is accepted
    reset_clear_a: assert property (@(posedge clk) disable iff (rst)
        !seen_accept |-> !valid_o && !branch_taken_o && !jump_o && !write_reg_o &&
            alu_result_o == '0 && target_o == '0)
        else flag_error("outputs not cleared after reset");
    ready_a: assert property (@(posedge clk) disable iff (rst)
        ready_o == (!valid_o || ready_i))
        else flag_error("ready_o does not follow valid_o and ready_i");
    latency_a: assert property (@(posedge clk) disable iff (rst)
        valid_i && ready_o |=> valid_o)
        else flag_error("accepted item not on the outputs one edge later");
    queue_a: assert property (@(posedge clk) disable iff (rst) valid_o |-> exp_count > 0)
        else flag_error("valid_o high with no accepted item outstanding");
    result_a: assert property (@(posedge clk) disable iff (rst)
        valid_o |-> alu_result_o == exp_result)
        else flag_error($sformatf("alu_result_o %h expected %h",
            $sampled(alu_result_o), $sampled(exp_result)));
    target_a: assert property (@(posedge clk) disable iff (rst)
        valid_o |-> target_o == exp_target)
        else flag_error($sformatf("target_o %h expected %h",
            $sampled(target_o), $sampled(exp_target)));
    taken_a: assert property (@(posedge clk) disable iff (rst)
        valid_o |-> branch_taken_o == exp_taken)
        else flag_error($sformatf("branch_taken_o %b expected %b",
            $sampled(branch_taken_o), $sampled(exp_taken)));
    jump_a: assert property (@(posedge clk) disable iff (rst)
        valid_o |-> jump_o == exp_jump)
        else flag_error($sformatf("jump_o %b expected %b",
            $sampled(jump_o), $sampled(exp_jump)));
    write_a: assert property (@(posedge clk) disable iff (rst)
        valid_o |-> write_reg_o == exp_write)
        else flag_error($sformatf("write_reg_o %b expected %b",
            $sampled(write_reg_o), $sampled(exp_write)));
    // stalled item holds every field
    hold_a: assert property (@(posedge clk) disable iff (rst)
        valid_o && !ready_i |=> valid_o && $stable(alu_result_o) && $stable(target_o) &&
            $stable(branch_taken_o) && $stable(jump_o) && $stable(write_reg_o))
        else flag_error("outputs changed while stalled");

    initial begin
        int          sent;
        logic        took;
        void'($urandom(32'hc22));
        clk        = 1'b0;
        rst        = 1'b1;
        valid_i    = 1'b0;
        ready_i    = 1'b0;
        inst_i     = '0;
        operand1_i = '0;
        operand2_i = '0;
        imm_i      = '0;
        pc_i       = '0;
        sent       = 0;
        repeat (3) @(posedge clk);
        #0.5;
        rst = 1'b0;
        while (sent < N_ITEMS) begin
            @(posedge clk);
            took = valid_i && ready_o;
            if (took) sent++;
            #0.5;
            // consumer ready about 70% of cycles
            ready_i = ($urandom % 10) < 7;
            if (sent >= N_ITEMS) begin
                valid_i = 1'b0;
            end else if (took || !valid_i) begin
                // occasional bubble upstream
                if ($urandom % 10 < 9) load_random_item();
                else valid_i = 1'b0;
            end
        end
        // drain what is still in flight
        ready_i = 1'b1;
        while (checked < N_ITEMS) begin
            @(posedge clk);
            #0.5;
        end
        repeat (2) @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("items still outstanding after the drain: %0d", exp_q.size());
            errors++;
        end
        $display("items checked: %0d, errors: %0d", checked, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/execute.sv */
`timescale 1ns/100ps
`default_nettype none

module execute import exec_pkg::*; (
    input  wire               i_clk,
    input  wire               rst_i,
    // upstream side
    input  wire               valid_i,
    output logic              ready_o,
    input  wire  [INST_W-1:0] inst_i,
    input  wire  [XLEN-1:0]   operand1_i,
    input  wire  [XLEN-1:0]   operand2_i,
    input  wire  [XLEN-1:0]   imm_i,
    input  wire  [XLEN-1:0]   pc_i,
    // downstream side
    output logic              valid_o,
    input  wire               ready_i,
    output logic [XLEN-1:0]   alu_result_o,
    output logic [XLEN-1:0]   target_o,
    output logic              branch_taken_o,
    output logic              jump_o,
    output logic              write_reg_o
);

    logic [ALU_OP_W-1:0] alu_op;
    logic                use_imm;
    logic                is_branch;
    logic [BR_W-1:0]     br_cond;
    logic                is_jump;
    logic                jump_reg;
    logic [RES_W-1:0]    res_src;
    logic                write_en;
    logic [XLEN-1:0]     operand_b;
    logic [XLEN-1:0]     alu_value;
    logic                taken;
    logic [XLEN-1:0]     target;
    logic [XLEN-1:0]     link;
    logic [XLEN-1:0]     pc_imm;
    logic [XLEN-1:0]     result_d;

    // one-hot word to selects
    exec_op_classify u_classify (
        .i_clk       (i_clk),
        .valid_i     (valid_i),
        .inst_i      (inst_i),
        .alu_op_o    (alu_op),
        .use_imm_o   (use_imm),
        .is_branch_o (is_branch),
        .br_cond_o   (br_cond),
        .is_jump_o   (is_jump),
        .jump_reg_o  (jump_reg),
        .res_src_o   (res_src),
        .write_reg_o (write_en)
    );

    // i-type, loads, stores and jalr take the immediate
    assign operand_b = use_imm ? imm_i : operand2_i;

    exec_alu u_alu (
        .op_i     (alu_op),
        .a_i      (operand1_i),
        .b_i      (operand_b),
        .result_o (alu_value)
    );

    // branch compare always sees rs2, never the immediate
    exec_branch_unit u_branch (
        .rs1_i       (operand1_i),
        .rs2_i       (operand2_i),
        .imm_i       (imm_i),
        .pc_i        (pc_i),
        .is_branch_i (is_branch),
        .br_cond_i   (br_cond),
        .is_jump_i   (is_jump),
        .jump_reg_i  (jump_reg),
        .taken_o     (taken),
        .target_o    (target),
        .link_o      (link),
        .pc_imm_o    (pc_imm)
    );

    // primary result mux
    always_comb begin
        case (res_src)
            RES_LINK:   result_d = link;
            RES_PC_IMM: result_d = pc_imm;
            default:    result_d = alu_value;
        endcase
    end

    // one cycle to the outputs
    exec_result_reg u_out (
        .i_clk          (i_clk),
        .rst_i          (rst_i),
        .valid_i        (valid_i),
        .ready_o        (ready_o),
        .valid_o        (valid_o),
        .ready_i        (ready_i),
        .result_d_i     (result_d),
        .target_d_i     (target),
        .taken_d_i      (taken),
        .jump_d_i       (is_jump),
        .write_d_i      (write_en),
        .result_o       (alu_result_o),
        .target_o       (target_o),
        .branch_taken_o (branch_taken_o),
        .jump_o         (jump_o),
        .write_reg_o    (write_reg_o)
    );

endmodule

`default_nettype wire

/* verilog/exec_result_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_result_reg import exec_pkg::*; (
    input  wire             i_clk,
    input  wire             rst_i,
    input  wire             valid_i,
    output logic            ready_o,
    output logic            valid_o,
    input  wire             ready_i,
    input  wire  [XLEN-1:0] result_d_i,
    input  wire  [XLEN-1:0] target_d_i,
    input  wire             taken_d_i,
    input  wire             jump_d_i,
    input  wire             write_d_i,
    output logic [XLEN-1:0] result_o,
    output logic [XLEN-1:0] target_o,
    output logic            branch_taken_o,
    output logic            jump_o,
    output logic            write_reg_o
);

    logic load;

    // single slot, refilled in the cycle it drains
    assign ready_o = !valid_o || ready_i;
    assign load    = valid_i && ready_o;

    always_ff @(posedge i_clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else if (ready_o) begin
            valid_o <= valid_i;
        end
    end

    // fields only move on an accepted transfer
    always_ff @(posedge i_clk) begin
        if (rst_i) begin
            result_o       <= '0;
            target_o       <= '0;
            branch_taken_o <= 1'b0;
            jump_o         <= 1'b0;
            write_reg_o    <= 1'b0;
        end else if (load) begin
            result_o       <= result_d_i;
            target_o       <= target_d_i;
            branch_taken_o <= taken_d_i;
            jump_o         <= jump_d_i;
            write_reg_o    <= write_d_i;
        end
    end

    // stalled item must not change before the consumer takes it
    hold_under_stall_a: assert property (@(posedge i_clk) disable iff (rst_i)
        valid_o && !ready_i |=> valid_o && $stable(result_o) && $stable(target_o) &&
            $stable(branch_taken_o) && $stable(jump_o) && $stable(write_reg_o))
        else $error("execute: output changed while stalled");

endmodule

`default_nettype wire

/* verilog/exec_branch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_branch_unit import exec_pkg::*; (
    input  wire  [XLEN-1:0] rs1_i,
    input  wire  [XLEN-1:0] rs2_i,
    input  wire  [XLEN-1:0] imm_i,
    input  wire  [XLEN-1:0] pc_i,
    input  wire             is_branch_i,
    input  wire  [BR_W-1:0] br_cond_i,
    input  wire             is_jump_i,
    input  wire             jump_reg_i,
    output logic            taken_o,
    output logic [XLEN-1:0] target_o,
    output logic [XLEN-1:0] link_o,
    output logic [XLEN-1:0] pc_imm_o
);

    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic            cond_met;
    logic [XLEN-1:0] rs1_imm;

    // operand compares
    assign eq   = rs1_i == rs2_i;
    assign lt_s = $signed(rs1_i) < $signed(rs2_i);
    assign lt_u = rs1_i < rs2_i;

    always_comb begin
        case (br_cond_i)
            BR_EQ:   cond_met = eq;
            BR_NE:   cond_met = !eq;
            BR_LT:   cond_met = lt_s;
            BR_GE:   cond_met = !lt_s;
            BR_LTU:  cond_met = lt_u;
            BR_GEU:  cond_met = !lt_u;
            default: cond_met = 1'b0;
        endcase
    end

    // non-branch words never report taken
    assign taken_o = is_branch_i & cond_met;

    // pc relative sum, also the auipc result
    assign pc_imm_o = pc_i + imm_i;
    assign rs1_imm  = rs1_i + imm_i;

    // return address for jal/jalr
    assign link_o = pc_i + LINK_OFFSET;

    // jalr goes register relative, other control flow pc relative
    always_comb begin
        if (jump_reg_i) begin
            target_o = rs1_imm;
        end else if (is_branch_i || is_jump_i) begin
            target_o = pc_imm_o;
        end else begin
            // plain alu and address ops
            target_o = '0;
        end
    end

endmodule

`default_nettype wire

/* verilog/exec_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_alu import exec_pkg::*; (
    input  wire  [ALU_OP_W-1:0] op_i,
    input  wire  [XLEN-1:0]     a_i,
    input  wire  [XLEN-1:0]     b_i,
    output logic [XLEN-1:0]     result_o
);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;
    logic [XLEN-1:0]    sum;
    logic [XLEN-1:0]    diff;

    // only the low five bits shift, as in rv32i
    assign shamt = b_i[SHAMT_W-1:0];

    // set-less-than compares
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    assign sum  = a_i + b_i;
    assign diff = a_i - b_i;

    always_comb begin
        case (op_i)
            ALU_ADD: begin
                result_o = sum;
            end
            ALU_SUB: begin
                result_o = diff;
            end
            // bitwise
            ALU_XOR: begin
                result_o = a_i ^ b_i;
            end
            ALU_OR: begin
                result_o = a_i | b_i;
            end
            ALU_AND: begin
                result_o = a_i & b_i;
            end
            // shifts
            ALU_SLL: begin
                result_o = a_i << shamt;
            end
            ALU_SRL: begin
                result_o = a_i >> shamt;
            end
            ALU_SRA: begin
                // sign bit fills from the left
                result_o = $unsigned($signed(a_i) >>> shamt);
            end
            // compare result in bit 0
            ALU_SLT: begin
                result_o = {{(XLEN-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            // ALU_PASS_ZERO and unused codes
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/exec_op_classify.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_op_classify import exec_pkg::*; (
    input  wire                i_clk,
    input  wire                valid_i,
    input  wire [INST_W-1:0]   inst_i,
    output logic [ALU_OP_W-1:0] alu_op_o,
    output logic               use_imm_o,
    output logic               is_branch_o,
    output logic [BR_W-1:0]    br_cond_o,
    output logic               is_jump_o,
    output logic               jump_reg_o,
    output logic [RES_W-1:0]   res_src_o,
    output logic               write_reg_o
);

    logic rr_grp;
    logic ri_grp;
    logic ld_grp;
    logic st_grp;
    logic br_grp;

    // instruction groups
    assign rr_grp = inst_i[INST_ADD] | inst_i[INST_SUB] | inst_i[INST_XOR] |
                    inst_i[INST_OR] | inst_i[INST_AND] | inst_i[INST_SLL] |
                    inst_i[INST_SRL] | inst_i[INST_SRA] | inst_i[INST_SLT] |
                    inst_i[INST_SLTU];
    assign ri_grp = inst_i[INST_ADDI] | inst_i[INST_XORI] | inst_i[INST_ORI] |
                    inst_i[INST_ANDI] | inst_i[INST_SLLI] | inst_i[INST_SRLI] |
                    inst_i[INST_SRAI] | inst_i[INST_SLTI] | inst_i[INST_SLTIU];
    assign ld_grp = inst_i[INST_LB] | inst_i[INST_LH] | inst_i[INST_LW] |
                    inst_i[INST_LBU] | inst_i[INST_LHU];
    assign st_grp = inst_i[INST_SB] | inst_i[INST_SH] | inst_i[INST_SW];
    assign br_grp = inst_i[INST_BEQ] | inst_i[INST_BNE] | inst_i[INST_BLT] |
                    inst_i[INST_BGE] | inst_i[INST_BLTU] | inst_i[INST_BGEU];

    // alu op per set bit, address generation and jalr share the adder
    always_comb begin
        case (1'b1)
            inst_i[INST_ADD], inst_i[INST_ADDI], ld_grp, st_grp, inst_i[INST_JALR]:
                alu_op_o = ALU_ADD;
            inst_i[INST_SUB]:                       alu_op_o = ALU_SUB;
            inst_i[INST_XOR], inst_i[INST_XORI]:    alu_op_o = ALU_XOR;
            inst_i[INST_OR], inst_i[INST_ORI]:      alu_op_o = ALU_OR;
            inst_i[INST_AND], inst_i[INST_ANDI]:    alu_op_o = ALU_AND;
            inst_i[INST_SLL], inst_i[INST_SLLI]:    alu_op_o = ALU_SLL;
            inst_i[INST_SRL], inst_i[INST_SRLI]:    alu_op_o = ALU_SRL;
            inst_i[INST_SRA], inst_i[INST_SRAI]:    alu_op_o = ALU_SRA;
            inst_i[INST_SLT], inst_i[INST_SLTI]:    alu_op_o = ALU_SLT;
            inst_i[INST_SLTU], inst_i[INST_SLTIU]:  alu_op_o = ALU_SLTU;
            // branches, unknown, dropped and zero word
            default:                                alu_op_o = ALU_PASS_ZERO;
        endcase
    end

    // compare kind, only looked at when is_branch_o is set
    always_comb begin
        case (1'b1)
            inst_i[INST_BNE]:  br_cond_o = BR_NE;
            inst_i[INST_BLT]:  br_cond_o = BR_LT;
            inst_i[INST_BGE]:  br_cond_o = BR_GE;
            inst_i[INST_BLTU]: br_cond_o = BR_LTU;
            inst_i[INST_BGEU]: br_cond_o = BR_GEU;
            default:           br_cond_o = BR_EQ;
        endcase
    end

    // operand b from immediate
    assign use_imm_o   = ri_grp | ld_grp | st_grp | inst_i[INST_JALR];
    assign is_branch_o = br_grp;
    assign is_jump_o   = inst_i[INST_JAL] | inst_i[INST_JALR];
    assign jump_reg_o  = inst_i[INST_JALR];

    // jumps return the link, auipc returns pc+imm
    assign res_src_o = is_jump_o          ? RES_LINK   :
                       inst_i[INST_AUIPC] ? RES_PC_IMM : RES_ALU;

    // stores, branches and unknown words write nothing
    assign write_reg_o = rr_grp | ri_grp | ld_grp | is_jump_o | inst_i[INST_AUIPC];

    // decoder must hand over a single instruction bit or none
    inst_onehot_a: assert property (@(posedge i_clk) valid_i |-> $onehot0(inst_i))
        else $error("execute: instruction word not one-hot: %h", inst_i);

endmodule

`default_nettype wire

/* verilog/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    // datapath widths
    localparam int XLEN    = 32;
    localparam int SHAMT_W = 5;
    localparam int INST_W  = 64;

    // bit positions in the one-hot instruction word
    // bit 0 is the unknown slot, 37 and up are dropped system/fence/csr/lui
    // register-register ops
    localparam int INST_ADD   = 1;
    localparam int INST_SUB   = 2;
    localparam int INST_XOR   = 3;
    localparam int INST_OR    = 4;
    localparam int INST_AND   = 5;
    localparam int INST_SLL   = 6;
    localparam int INST_SRL   = 7;
    localparam int INST_SRA   = 8;
    localparam int INST_SLT   = 9;
    localparam int INST_SLTU  = 10;
    // register-immediate ops
    localparam int INST_ADDI  = 11;
    localparam int INST_XORI  = 12;
    localparam int INST_ORI   = 13;
    localparam int INST_ANDI  = 14;
    localparam int INST_SLLI  = 15;
    localparam int INST_SRLI  = 16;
    localparam int INST_SRAI  = 17;
    localparam int INST_SLTI  = 18;
    localparam int INST_SLTIU = 19;
    // loads, address only
    localparam int INST_LB    = 20;
    localparam int INST_LH    = 21;
    localparam int INST_LW    = 22;
    localparam int INST_LBU   = 23;
    localparam int INST_LHU   = 24;
    // stores, address only
    localparam int INST_SB    = 25;
    localparam int INST_SH    = 26;
    localparam int INST_SW    = 27;
    // conditional branches
    localparam int INST_BEQ   = 28;
    localparam int INST_BNE   = 29;
    localparam int INST_BLT   = 30;
    localparam int INST_BGE   = 31;
    localparam int INST_BLTU  = 32;
    localparam int INST_BGEU  = 33;
    // jumps and pc-relative
    localparam int INST_JAL   = 34;
    localparam int INST_JALR  = 35;
    localparam int INST_AUIPC = 36;

    // alu operation select
    localparam int ALU_OP_W = 4;

    localparam logic [ALU_OP_W-1:0] ALU_ADD       = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB       = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_XOR       = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR        = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_AND       = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLL       = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL       = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA       = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SLT       = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU      = 4'd9;
    // result forced to zero, for branches and unknown words
    localparam logic [ALU_OP_W-1:0] ALU_PASS_ZERO = 4'd15;

    // branch condition select
    localparam int BR_W = 3;

    localparam logic [BR_W-1:0] BR_EQ  = 3'd0;
    localparam logic [BR_W-1:0] BR_NE  = 3'd1;
    localparam logic [BR_W-1:0] BR_LT  = 3'd2;
    localparam logic [BR_W-1:0] BR_GE  = 3'd3;
    localparam logic [BR_W-1:0] BR_LTU = 3'd4;
    localparam logic [BR_W-1:0] BR_GEU = 3'd5;

    // primary result source
    localparam int RES_W = 2;

    localparam logic [RES_W-1:0] RES_ALU    = 2'd0;
    localparam logic [RES_W-1:0] RES_LINK   = 2'd1;
    localparam logic [RES_W-1:0] RES_PC_IMM = 2'd2;

    // return address step for jal/jalr
    localparam logic [XLEN-1:0] LINK_OFFSET = 32'd4;

endpackage

`default_nettype wire
